/* motion_core.f */
verilog/motion_pkg.sv
verilog/word_decoder.sv
verilog/control_registers.sv
verilog/move_buffer.sv
verilog/move_sequencer.sv
verilog/dda_axis.sv
verilog/motion_core.sv
test/clock_gen.sv
test/motion_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= motion_core_tb
FILELIST  ?= motion_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* test/motion_core_tb.sv */
`timescale 1ns/1ps
// Motion core testbench

module motion_core_tb import motion_pkg::*; ();

  localparam int num_motors = 2;
  localparam int buffer_size = 2;
  localparam int default_clock_divisor = 32;
  localparam int wait_limit = 2000;       // Cycles allowed per wait

  logic                  CLK;
  logic                  resetn;
  word_t                 word_data_received;
  logic                  word_received;
  word_t                 word_send_data;
  logic [num_motors-1:0] step;
  logic [num_motors-1:0] dir;
  logic [num_motors-1:0] enable;
  logic                  move_done;
  logic                  buffer_dtr;

  int          errors;
  int          timeouts;
  logic [15:0] lfsr_state;

  // Move 0 single, 1 and 2 queued, 3 dropped
  logic [num_motors-1:0] move_dir [4];
  duration_t             dur [4];
  word_t                 vel [4][num_motors];
  word_t                 acc [4][num_motors];

  // Step tallies logged at each move_done
  int                    step_count [num_motors];
  int                    done_count;
  int                    done_steps [4][num_motors];
  logic [num_motors-1:0] done_dir [4];

  clock_gen clock_i (.CLK(CLK), .resetn(resetn));

  motion_core #(
    .num_motors           (num_motors),
    .buffer_size          (buffer_size),
    .default_clock_divisor(default_clock_divisor)
  ) motion_core_i (
    .CLK               (CLK),
    .resetn            (resetn),
    .word_data_received(word_data_received),
    .word_received     (word_received),
    .word_send_data    (word_send_data),
    .step              (step),
    .dir               (dir),
    .enable            (enable),
    .move_done         (move_done),
    .buffer_dtr        (buffer_dtr)
  );

  always @(negedge CLK) begin
    if (!resetn) begin
      for (int m = 0; m < num_motors; m++) step_count[m] = 0;
      done_count = 0;
    end else begin
      for (int m = 0; m < num_motors; m++) begin
        if (step[m]) step_count[m]++;
      end
      if (move_done) begin
        if (done_count < 4) begin
          for (int m = 0; m < num_motors; m++) done_steps[done_count][m] = step_count[m];
          done_dir[done_count] = dir;
        end
        for (int m = 0; m < num_motors; m++) step_count[m] = 0;
        done_count++;
      end
    end
  end

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    assert (actual === expected) else begin
      errors++;
      $display("Error: %s = 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic take_random(input int nbits, output word_t value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[WORD_BITS-2:0], lfsr_state[0]};
    end
  endtask

  // Reference DDA, one pass per tick
  function automatic int model_steps(input word_t velocity, input word_t accel,
                                     input duration_t duration);
    logic [WORD_BITS:0] total;
    word_t              phase;
    word_t              rate;
    int                 ticks;
    int                 steps;
    phase = '0;
    rate  = velocity;
    steps = 0;
    ticks = (duration == 0) ? 1 : int'(duration);  // Zero length still takes one tick
    for (int t = 0; t < ticks; t++) begin
      total = {1'b0, phase} + {1'b0, rate};
      if (total[WORD_BITS]) steps++;
      phase = total[WORD_BITS-1:0];
      rate  = rate + accel;
    end
    return steps;
  endfunction

  task automatic send_word(input word_t value);
    @(negedge CLK);
    word_data_received = value;
    word_received      = 1'b1;
    repeat (2) @(negedge CLK);   // Reply settles by the second rising edge
    word_received = 1'b0;
    repeat (2) @(negedge CLK);
  endtask

  task automatic read_status(input logic [7:0] addr, output word_t reply);
    send_word({CMD_STATUS_REG, 48'h0, addr});
    reply = word_send_data;
  endtask

  // Header returns the old value, the next word writes
  task automatic access_config(input logic [7:0] addr, input word_t value, output word_t reply);
    send_word({CMD_CONFIG_REG, 48'h0, addr});
    reply = word_send_data;
    send_word(value);
    check_value("word_send_data", word_send_data, '0);
  endtask

  task automatic send_move(input int k);
    send_word({CMD_COORDINATED_STEP, 56'(move_dir[k])});
    send_word(word_t'(dur[k]));
    for (int m = 0; m < num_motors; m++) begin
      send_word(vel[k][m]);
      send_word(acc[k][m]);
    end
  endtask

  task automatic wait_reset_release();
    bit released;
    released = 1'b0;
    for (int i = 0; i < 20 && !released; i++) begin
      @(posedge CLK);
      released = resetn;
    end
    if (!released) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    @(negedge CLK);
  endtask

  task automatic wait_move_done(input bit check_dir, input logic [num_motors-1:0] exp_dir);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < wait_limit && !seen; i++) begin
      @(negedge CLK);
      if (check_dir) check_value("dir", word_t'(dir), word_t'(exp_dir));
      seen = move_done;
    end
    if (!seen) begin
      timeouts++;
      $display("Timeout: move_done did not pulse within %0d cycles", wait_limit);
    end
    @(posedge CLK);   // Monitor has logged the pulse by now
  endtask

  task automatic check_move(input int k);
    for (int m = 0; m < num_motors; m++) begin
      check_value($sformatf("step[%0d] count", m), word_t'(done_steps[k][m]),
                  word_t'(model_steps(vel[k][m], acc[k][m], dur[k])));
    end
    check_value("dir", word_t'(done_dir[k]), word_t'(move_dir[k]));
  endtask

  task automatic build_moves();
    move_dir[0] = 2'b10;
    move_dir[1] = 2'b01;
    move_dir[2] = 2'b11;
    move_dir[3] = 2'b10;
    dur[0] = 12;
    dur[1] = 40;      // Long enough to hold both slots during moves 2 and 3
    dur[2] = 20;
    dur[3] = 5;
    for (int m = 0; m < num_motors; m++) begin
      take_random(64, vel[0][m]);
      acc[0][m] = '0;
      take_random(62, vel[1][m]);
      take_random(56, acc[1][m]);
      take_random(62, vel[2][m]);
      take_random(56, acc[2][m]);
      take_random(64, vel[3][m]);
      acc[3][m] = '0;
    end
  endtask

  initial begin
    word_t reply;
    errors             = 0;
    timeouts           = 0;
    lfsr_state         = 16'd97;
    word_data_received = '0;
    word_received      = 1'b0;
    wait_reset_release();

    check_value("buffer_dtr", buffer_dtr, 1);
    check_value("step", step, 0);
    check_value("enable", enable, 0);
    check_value("move_done", move_done, 0);
    check_value("word_send_data", word_send_data, 0);
    check_value("dir", dir, 0);

    read_status(STATUS_VERSION_ADDR, reply);
    check_value("word_send_data", reply, word_t'(VERSION_WORD));
    read_status(STATUS_CHANNEL_ADDR, reply);
    check_value("word_send_data", reply, (word_t'(WORD_BITS) << 16) |
                (word_t'(buffer_size) << 8) | word_t'(num_motors));
    read_status(8'h07, reply);
    check_value("word_send_data", reply, 0);

    // Faster ticks for the moves
    access_config(CONFIG_CLOCKS_ADDR, 64'd4, reply);
    check_value("word_send_data", reply, word_t'(default_clock_divisor));
    access_config(CONFIG_CLOCKS_ADDR, 64'd4, reply);
    check_value("word_send_data", reply, 4);
    access_config(CONFIG_ENABLE_ADDR, 64'h3, reply);
    check_value("word_send_data", reply, 0);
    check_value("enable", enable, 3);
    access_config(CONFIG_ENABLE_ADDR, 64'h3, reply);
    check_value("word_send_data", reply, 3);

    build_moves();
    send_move(0);
    wait_move_done(1'b1, move_dir[0]);
    check_move(0);
    repeat (200) @(negedge CLK);
    check_true(done_count == 1, $sformatf("Single move gave %0d move_done pulses", done_count));
    check_value("buffer_dtr", buffer_dtr, 1);

    send_move(1);
    check_value("buffer_dtr", buffer_dtr, 1);
    send_move(2);
    check_value("buffer_dtr", buffer_dtr, 0);
    send_move(3);     // Buffer full, so this one is dropped
    check_value("buffer_dtr", buffer_dtr, 0);
    wait_move_done(1'b0, '0);
    check_move(1);
    wait_move_done(1'b0, '0);
    check_move(2);
    repeat (600) @(negedge CLK);
    check_true(done_count == 3, $sformatf("Expected 3 moves in total, saw %0d", done_count));
    check_value("buffer_dtr", buffer_dtr, 1);

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* test/clock_gen.sv */
`timescale 1ns/1ps
// Testbench clock and reset

module clock_gen #(
  parameter int half_period = 2,   // 4 ns period
  parameter int reset_cycles = 2
) (
  output logic CLK,
  output logic resetn
);

  initial begin
    CLK = 1'b0;
    forever #(half_period) CLK = ~CLK;
  end

  // Released on a falling edge like the other inputs
  initial begin
    resetn = 1'b0;
    repeat (reset_cycles) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b1;
  end

endmodule

/* verilog/motion_core.sv */
`timescale 1ns/1ps
// Stepper motion controller top

module motion_core import motion_pkg::*; #(
  parameter int num_motors = 2,
  parameter int buffer_size = 2,
  parameter int default_clock_divisor = 32
) (
  input  logic                  CLK,
  input  logic                  resetn,
  input  word_t                 word_data_received,
  input  logic                  word_received,
  output word_t                 word_send_data,
  output logic [num_motors-1:0] step,
  output logic [num_motors-1:0] dir,
  output logic [num_motors-1:0] enable,
  output logic                  move_done,
  output logic                  buffer_dtr
);

  // Decoder strobes
  logic       word_seen;
  logic       status_read;
  logic       config_read;
  logic       config_write;
  logic [7:0] config_addr;
  logic       move_header;
  logic       move_word;
  logic       move_commit;
  logic [7:0] move_index;
  word_t      word_data;

  // Buffer to sequencer and axes
  divisor_t  clock_divisor;
  logic      slot_pending;
  logic      slot_release;
  duration_t move_duration;
  word_t     velocity [num_motors];
  word_t     accel [num_motors];
  logic      dda_tick;
  logic      load_move;
  logic      running;

  word_decoder #(
    .num_motors(num_motors)
  ) decoder_i (
    .CLK               (CLK),
    .resetn            (resetn),
    .word_data_received(word_data_received),
    .word_received     (word_received),
    .word_seen         (word_seen),
    .status_read       (status_read),
    .config_read       (config_read),
    .config_write      (config_write),
    .config_addr       (config_addr),
    .move_header       (move_header),
    .move_word         (move_word),
    .move_commit       (move_commit),
    .move_index        (move_index),
    .word_data         (word_data)
  );

  control_registers #(
    .num_motors           (num_motors),
    .buffer_size          (buffer_size),
    .default_clock_divisor(default_clock_divisor)
  ) registers_i (
    .CLK           (CLK),
    .resetn        (resetn),
    .status_read   (status_read),
    .config_read   (config_read),
    .config_write  (config_write),
    .config_addr   (config_addr),
    .word_data     (word_data),
    .word_seen     (word_seen),
    .word_send_data(word_send_data),
    .enable        (enable),
    .clock_divisor (clock_divisor)
  );

  move_buffer #(
    .num_motors (num_motors),
    .buffer_size(buffer_size)
  ) buffer_i (
    .CLK          (CLK),
    .resetn       (resetn),
    .move_header  (move_header),
    .move_word    (move_word),
    .move_commit  (move_commit),
    .move_index   (move_index),
    .word_data    (word_data),
    .slot_release (slot_release),
    .slot_pending (slot_pending),
    .move_duration(move_duration),
    .move_dir     (dir),            // Dir of the move in the read slot
    .velocity     (velocity),
    .accel        (accel),
    .buffer_dtr   (buffer_dtr)
  );

  move_sequencer sequencer_i (
    .CLK          (CLK),
    .resetn       (resetn),
    .clock_divisor(clock_divisor),
    .slot_pending (slot_pending),
    .move_duration(move_duration),
    .dda_tick     (dda_tick),
    .load_move    (load_move),
    .running      (running),
    .slot_release (slot_release),
    .move_done    (move_done)
  );

  for (genvar m = 0; m < num_motors; m++) begin : gen_axis
    dda_axis axis_i (
      .CLK      (CLK),
      .resetn   (resetn),
      .dda_tick (dda_tick),
      .load_move(load_move),
      .running  (running),
      .velocity (velocity[m]),
      .accel    (accel[m]),
      .step     (step[m])
    );
  end

endmodule

/* verilog/dda_axis.sv */
`timescale 1ns/1ps
// Single axis DDA step generator

module dda_axis import motion_pkg::*; (
  input  logic  CLK,
  input  logic  resetn,
  input  logic  dda_tick,
  input  logic  load_move,
  input  logic  running,
  input  word_t velocity,
  input  word_t accel,
  output logic  step
);

  word_t accumulator;
  word_t rate;
  word_t sum;
  logic  carry;

  // Carry out of the top bit marks a step
  assign {carry, sum} = {1'b0, accumulator} + {1'b0, rate};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      accumulator <= '0;
      rate        <= '0;
      step        <= 1'b0;
    end else begin
      step <= 1'b0;
      if (load_move) begin
        accumulator <= '0;
        rate        <= velocity;  // Initial rate of the new move
      end else if (running && dda_tick) begin
        accumulator <= sum;
        rate        <= rate + accel;
        step        <= carry;
      end
    end
  end

endmodule

/* verilog/move_sequencer.sv */
`timescale 1ns/1ps
// DDA tick divider and move sequencer

module move_sequencer import motion_pkg::*; (
  input  logic      CLK,
  input  logic      resetn,
  input  divisor_t  clock_divisor,
  input  logic      slot_pending,
  input  duration_t move_duration,
  output logic      dda_tick,
  output logic      load_move,
  output logic      running,
  output logic      slot_release,
  output logic      move_done
);

  divisor_t   div_count;
  divisor_t   div_last;
  duration_t  ticks_left;
  seq_state_e state;
  logic       last_tick;

  // A divisor of 0 wraps to 255, giving 256 cycles
  assign div_last = clock_divisor - 1'b1;
  assign dda_tick = (div_count == div_last);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      div_count <= '0;
    end else if (div_count >= div_last) begin
      div_count <= '0;
    end else begin
      div_count <= div_count + 1'b1;
    end
  end

  assign load_move    = (state == SEQ_LOAD);
  assign running      = (state == SEQ_RUN);
  assign last_tick    = running && dda_tick && (ticks_left <= duration_t'(1));
  assign slot_release = move_done;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state      <= SEQ_IDLE;
      ticks_left <= '0;
      move_done  <= 1'b0;
    end else begin
      move_done <= last_tick;  // Lines up with the final step pulse
      case (state)
        SEQ_IDLE: begin
          // Slot being released is still flagged for one cycle
          if (slot_pending && !move_done) state <= SEQ_LOAD;
        end
        SEQ_LOAD: begin
          ticks_left <= move_duration;
          state      <= SEQ_RUN;
        end
        SEQ_RUN: begin
          if (dda_tick) begin
            ticks_left <= ticks_left - 1'b1;
            if (last_tick) state <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

/* verilog/move_buffer.sv */
`timescale 1ns/1ps
// Move slot storage

module move_buffer import motion_pkg::*; #(
  parameter int num_motors = 2,
  parameter int buffer_size = 2
) (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  move_header,
  input  logic                  move_word,
  input  logic                  move_commit,
  input  logic [7:0]            move_index,
  input  word_t                 word_data,
  input  logic                  slot_release,
  output logic                  slot_pending,
  output duration_t             move_duration,
  output logic [num_motors-1:0] move_dir,
  output word_t                 velocity [num_motors],
  output word_t                 accel [num_motors],
  output logic                  buffer_dtr
);

  localparam int IDX_BITS = (buffer_size > 1) ? $clog2(buffer_size) : 1;

  logic [buffer_size-1:0] pending;  // One flag per slot
  logic [IDX_BITS-1:0]    wr_idx;
  logic [IDX_BITS-1:0]    rd_idx;
  logic [num_motors-1:0]  dir_mem [buffer_size];
  duration_t              dur_mem [buffer_size];
  word_t                  vel_mem [buffer_size][num_motors];
  word_t                  acc_mem [buffer_size][num_motors];
  logic                   write_open;

  function automatic logic [IDX_BITS-1:0] next_idx(input logic [IDX_BITS-1:0] idx);
    if (idx == IDX_BITS'(buffer_size - 1)) return '0;
    return idx + 1'b1;
  endfunction

  assign write_open = !pending[wr_idx];
  assign buffer_dtr = write_open;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pending <= '0;
      wr_idx  <= '0;
      rd_idx  <= '0;
    end else begin
      if (move_commit && write_open) begin
        pending[wr_idx] <= 1'b1;
        wr_idx          <= next_idx(wr_idx);
      end
      if (slot_release) begin
        pending[rd_idx] <= 1'b0;
        rd_idx          <= next_idx(rd_idx);
      end
    end
  end

  // Dir bits from the low bits of the move header
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      for (int s = 0; s < buffer_size; s++) dir_mem[s] <= '0;
    end else if (move_header && write_open) begin
      dir_mem[wr_idx] <= word_data[num_motors-1:0];
    end
  end

  // Word 1 is duration, then velocity and accel per motor
  always_ff @(posedge CLK) begin
    if (move_word && write_open) begin
      if (move_index == 8'd1) dur_mem[wr_idx] <= word_data[DURATION_BITS-1:0];
      for (int m = 0; m < num_motors; m++) begin
        if (move_index == 8'(2 + 2 * m)) vel_mem[wr_idx][m] <= word_data;
        if (move_index == 8'(3 + 2 * m)) acc_mem[wr_idx][m] <= word_data;
      end
    end
  end

  assign slot_pending  = pending[rd_idx];
  assign move_duration = dur_mem[rd_idx];
  assign move_dir      = dir_mem[rd_idx];

  always_comb begin
    for (int m = 0; m < num_motors; m++) begin
      velocity[m] = vel_mem[rd_idx][m];
      accel[m]    = acc_mem[rd_idx][m];
    end
  end

endmodule

/* verilog/control_registers.sv */
`timescale 1ns/1ps
// Config and status registers

module control_registers import motion_pkg::*; #(
  parameter int num_motors = 2,
  parameter int buffer_size = 2,
  parameter int default_clock_divisor = 32
) (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  status_read,
  input  logic                  config_read,
  input  logic                  config_write,
  input  logic [7:0]            config_addr,
  input  word_t                 word_data,
  input  logic                  word_seen,
  output word_t                 word_send_data,
  output logic [num_motors-1:0] enable,
  output divisor_t              clock_divisor
);

  word_t channel_word;
  word_t status_value;
  word_t config_value;

  // Motors, buffer depth and word width, one byte each
  assign channel_word = word_t'({8'(WORD_BITS), 8'(buffer_size), 8'(num_motors)});

  always_comb begin
    case (config_addr)
      STATUS_VERSION_ADDR: status_value = word_t'(VERSION_WORD);
      STATUS_CHANNEL_ADDR: status_value = channel_word;
      default:             status_value = '0;
    endcase
    case (config_addr)
      CONFIG_ENABLE_ADDR: config_value = word_t'(enable);
      CONFIG_CLOCKS_ADDR: config_value = word_t'(clock_divisor);
      default:            config_value = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      enable        <= '0;
      clock_divisor <= divisor_t'(default_clock_divisor);
    end else if (config_write) begin
      case (config_addr)
        CONFIG_ENABLE_ADDR: enable <= word_data[num_motors-1:0];
        CONFIG_CLOCKS_ADDR: clock_divisor <= word_data[7:0];
        default: ;        // Writes to unmapped addresses are lost
      endcase
    end
  end

  // Reply is refreshed on every word
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      word_send_data <= '0;
    end else if (word_seen) begin
      if (status_read) word_send_data <= status_value;
      else if (config_read) word_send_data <= config_value;
      else word_send_data <= '0;
    end
  end

endmodule

/* verilog/word_decoder.sv */
`timescale 1ns/1ps
// Host word command decoder

module word_decoder import motion_pkg::*; #(
  parameter int num_motors = 2
) (
  input  logic       CLK,
  input  logic       resetn,
  input  word_t      word_data_received,
  input  logic       word_received,
  output logic       word_seen,
  output logic       status_read,
  output logic       config_read,
  output logic       config_write,
  output logic [7:0] config_addr,
  output logic       move_header,
  output logic       move_word,
  output logic       move_commit,
  output logic [7:0] move_index,
  output word_t      word_data
);

  localparam logic [7:0] LAST_INDEX = 8'(2 * num_motors + 1);

  logic       received_q;
  logic       received_qq;
  header_t    header_q;     // Zero while waiting for a header
  logic [7:0] word_count;
  logic [7:0] addr_q;
  header_t    word_header;
  logic       in_message;

  // Edge detect on the word level
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      received_q  <= 1'b0;
      received_qq <= 1'b0;
    end else begin
      received_q  <= word_received;
      received_qq <= received_q;
    end
  end

  // Capture the word together with the rising level
  always_ff @(posedge CLK) begin
    if (word_received && !received_q) begin
      word_data <= word_data_received;
    end
  end

  assign word_seen   = received_q & ~received_qq;
  assign word_header = word_data[WORD_BITS-1 -: 8];
  assign in_message  = (header_q != 8'h00);
  assign move_index  = word_count;

  // Reads address the current word, writes the latched one
  assign config_addr = (header_q == CMD_CONFIG_REG) ? addr_q : word_data[7:0];

  always_comb begin
    status_read  = 1'b0;
    config_read  = 1'b0;
    config_write = 1'b0;
    move_header  = 1'b0;
    move_word    = 1'b0;
    move_commit  = 1'b0;
    if (word_seen) begin
      if (!in_message) begin
        case (word_header)
          CMD_STATUS_REG:       status_read = 1'b1;
          CMD_CONFIG_REG:       config_read = 1'b1;
          CMD_COORDINATED_STEP: move_header = 1'b1;
          default: ;            // Unknown header, stay idle
        endcase
      end else begin
        case (header_q)
          CMD_CONFIG_REG: config_write = 1'b1;
          CMD_COORDINATED_STEP: begin
            move_word   = 1'b1;
            move_commit = (word_count == LAST_INDEX);
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      header_q   <= '0;
      word_count <= '0;
    end else if (word_seen) begin
      if (!in_message) begin
        word_count <= 8'd1;
        if (word_header == CMD_COORDINATED_STEP || word_header == CMD_CONFIG_REG) begin
          header_q <= word_header;  // Multi-word command
        end
      end else if (move_word && !move_commit) begin
        word_count <= word_count + 1'b1;
      end else begin
        header_q <= '0;             // Back to header mode
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (config_read) begin
      addr_q <= word_data[7:0];
    end
  end

endmodule

/* verilog/motion_pkg.sv */
// Motion controller shared definitions

package motion_pkg;

  localparam int WORD_BITS = 64;      // Host word width
  localparam int DURATION_BITS = 32;  // Move length in DDA ticks

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [7:0] header_t;
  typedef logic [DURATION_BITS-1:0] duration_t;
  typedef logic [7:0] divisor_t;

  // Header byte of a command word
  typedef enum header_t {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_STATUS_REG       = 8'hF1,
    CMD_CONFIG_REG       = 8'hF2
  } cmd_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LOAD,
    SEQ_RUN
  } seq_state_e;

  // Status register map
  localparam logic [7:0] STATUS_VERSION_ADDR = 8'd0;
  localparam logic [7:0] STATUS_CHANNEL_ADDR = 8'd1;

  // Config register map
  localparam logic [7:0] CONFIG_ENABLE_ADDR = 8'd0;
  localparam logic [7:0] CONFIG_CLOCKS_ADDR = 8'd1;

  // Major, minor, patch in the low three bytes
  localparam logic [31:0] VERSION_WORD = 32'h0001_0300;

endpackage
